/* Bender.yml */
package:
  name: scope

sources:
  - design/scope_pkg.sv
  - design/sample_stream_if.sv
  - design/scope_regs.sv
  - design/scope_dec_avg.sv
  - design/scope_edge.sv
  - design/scope_acq.sv
  - design/scope_top.sv
  - target: test
    files:
      - verification/scope_tb.sv

/* all.f */
design/scope_pkg.sv
design/sample_stream_if.sv
design/scope_regs.sv
design/scope_dec_avg.sv
design/scope_edge.sv
design/scope_acq.sv
design/scope_top.sv
verification/scope_tb.sv

/* design/sample_stream_if.sv */
//////////////////////////////
// sample stream
// valid/ready handshake carrying one
// sample per beat plus a last flag
//////////////////////////////

`timescale 1ns/1ps

interface sample_stream_if import scope_pkg::*; #(
  parameter type sample_type = sample_t
) ();

  // payload
  sample_type data;
  logic       last;
  // handshake
  logic       valid;
  logic       ready;

  // producer side
  modport source (
    output data,
    output valid,
    output last,
    input  ready
  );

  // consumer side
  modport sink (
    input  data,
    input  valid,
    input  last,
    output ready
  );

endinterface

/* design/scope_acq.sv */
//////////////////////////////
// acquisition sequencer
// forwards a pre-trigger run, waits for a
// trigger, then forwards a post-trigger run
//////////////////////////////

`timescale 1ns/1ps

module scope_acq import scope_pkg::*; #(
  parameter type sample_type = sample_t
) (
  input  logic             bus,
  input  logic             reset,
  input  scope_cfg_t       cfg,
  input  scope_ctl_t       ctl,
  input  logic [EVT_W-1:0] ext_event,
  input  logic             edge_trg,
  sample_stream_if.sink    sti,
  sample_stream_if.source  sto,
  output logic [CNT_W-1:0] sts_pre,
  output logic [CNT_W-1:0] sts_pst,
  output logic             sts_armed,
  output logic             sts_stopped,
  output logic             sts_triggered
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PRE,   // forwarding pre-trigger samples
    ST_ARM,   // waiting for a trigger
    ST_PST    // forwarding post-trigger samples
  } acq_state_t;

  acq_state_t state;
  acq_state_t run_start;
  acq_state_t run_end;
  logic       active;
  logic       xfer;
  logic       trg;
  logic       pre_end;
  logic       pst_end;

  //////////////////////////////
  // stream path
  //////////////////////////////

  // idle and waiting states accept and drop samples
  assign active    = (state == ST_PRE) || (state == ST_PST);
  assign sti.ready = active ? sto.ready : 1'b1;
  assign sto.valid = active & sti.valid;
  assign sto.data  = sti.data;
  assign sto.last  = (state == ST_PST) & pst_end;
  assign xfer      = sto.valid & sto.ready;

  // any enabled trigger source
  assign trg = ctl.trg | edge_trg | (|(ext_event & cfg.msk));

  // final sample of each run
  assign pre_end = (sts_pre == cfg.pre - 1'b1);
  assign pst_end = (sts_pst == cfg.pst - 1'b1);

  // empty pre run goes straight to waiting
  assign run_start = (cfg.pre == '0) ? ST_ARM : ST_PRE;
  assign run_end   = cfg.con ? run_start : ST_IDLE;

  assign sts_armed = (state != ST_IDLE);

  //////////////////////////////
  // sequencer
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      state         <= ST_IDLE;
      sts_pre       <= '0;
      sts_pst       <= '0;
      sts_stopped   <= 1'b0;
      sts_triggered <= 1'b0;
    end else if (ctl.rst || ctl.stp) begin
      // abort from any state
      state <= ST_IDLE;
      if (ctl.stp) begin
        sts_stopped <= 1'b1;
      end
    end else begin
      case (state)
        ST_IDLE: begin
          if (ctl.str) begin
            state         <= run_start;
            sts_pre       <= '0;
            sts_pst       <= '0;
            sts_stopped   <= 1'b0;
            sts_triggered <= 1'b0;
          end
        end
        ST_PRE: begin
          if (xfer) begin
            sts_pre <= sts_pre + 1'b1;
            if (pre_end) begin
              state <= ST_ARM;
            end
          end
        end
        ST_ARM: begin
          if (trg) begin
            sts_triggered <= 1'b1;
            // no post run requested, the run ends here
            state <= (cfg.pst == '0) ? ST_IDLE : ST_PST;
          end
        end
        ST_PST: begin
          if (xfer) begin
            sts_pst <= sts_pst + 1'b1;
            if (pst_end) begin
              state <= run_end;
              // continuous mode re-arms with fresh counts
              if (cfg.con) begin
                sts_pre       <= '0;
                sts_pst       <= '0;
                sts_triggered <= 1'b0;
              end
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* design/scope_dec_avg.sv */
//////////////////////////////
// decimator
// keeps one sample out of each group, or
// the shifted sum of the group when averaging
//////////////////////////////

`timescale 1ns/1ps

module scope_dec_avg import scope_pkg::*; #(
  parameter type sample_type = sample_t
) (
  input  logic       bus,
  input  logic       reset,
  input  scope_cfg_t cfg,
  input  scope_ctl_t ctl,
  sample_stream_if.sink   sti,
  sample_stream_if.source sto
);

  // room for a full group of samples
  localparam int unsigned ACC_W = $bits(sample_type) + DEC_W;

  logic [DEC_W-1:0]        cnt;
  logic signed [ACC_W-1:0] acc;
  logic signed [ACC_W-1:0] sum;
  logic                    take;
  logic                    grp_end;

  // stall input while the result waits
  assign sti.ready = ~sto.valid | sto.ready;
  assign take      = sti.valid & sti.ready;

  // factor 0 or 1 ends a group on every sample
  assign grp_end = (cfg.dec <= DEC_W'(1)) || (cnt == cfg.dec - 1'b1);

  // running sum including the current sample
  assign sum = acc + ACC_W'($signed(sti.data));

  always_ff @(posedge bus) begin
    if (reset) begin
      cnt       <= '0;
      acc       <= '0;
      sto.valid <= 1'b0;
    end else begin
      // output valid one cycle after the group closes
      if (take && grp_end) begin
        sto.valid <= 1'b1;
      end else if (sto.ready) begin
        sto.valid <= 1'b0;
      end
      // group counter and accumulator
      if (ctl.rst) begin
        cnt <= '0;
        acc <= '0;
      end else if (take) begin
        cnt <= grp_end ? '0 : cnt + 1'b1;
        acc <= grp_end ? '0 : sum;
      end
    end
  end

  // result register
  always_ff @(posedge bus) begin
    if (take && grp_end) begin
      // arithmetic shift keeps negative sums negative
      sto.data <= cfg.avg ? sample_type'(sum >>> cfg.shr) : sti.data;
      sto.last <= sti.last;
    end
  end

endmodule

/* design/scope_edge.sv */
//////////////////////////////
// level trigger
// hysteresis edge detect on a passing
// stream, one register stage deep
//////////////////////////////

`timescale 1ns/1ps

module scope_edge import scope_pkg::*; #(
  parameter type sample_type = sample_t
) (
  input  logic       bus,
  input  logic       reset,
  input  scope_cfg_t cfg,
  input  scope_ctl_t ctl,
  sample_stream_if.sink   sti,
  sample_stream_if.source sto,
  output logic       edge_trg
);

  logic armed;
  logic take;
  logic arm_cond;
  logic fire;

  // one deep pipeline stage
  assign sti.ready = ~sto.valid | sto.ready;
  assign take      = sti.valid & sti.ready;

  // arm on the far side, fire on crossing the near level
  always_comb begin
    if (cfg.edg) begin
      // falling
      arm_cond = $signed(sti.data) > cfg.pos;
      fire     = armed && ($signed(sti.data) <= cfg.neg);
    end else begin
      // rising
      arm_cond = $signed(sti.data) < cfg.neg;
      fire     = armed && ($signed(sti.data) >= cfg.pos);
    end
  end

  always_ff @(posedge bus) begin
    if (reset) begin
      sto.valid <= 1'b0;
      armed     <= 1'b0;
      edge_trg  <= 1'b0;
    end else begin
      // pulse only in the first valid cycle of its beat
      edge_trg <= take & fire;
      if (take) begin
        sto.valid <= 1'b1;
      end else if (sto.ready) begin
        sto.valid <= 1'b0;
      end
      if (ctl.rst) begin
        armed <= 1'b0;
      end else if (take) begin
        if (fire) begin
          armed <= 1'b0;
        end else if (arm_cond) begin
          armed <= 1'b1;
        end
      end
    end
  end

  // sample register
  always_ff @(posedge bus) begin
    if (take) begin
      sto.data <= sti.data;
      sto.last <= sti.last;
    end
  end

endmodule

/* design/scope_pkg.sv */
//////////////////////////////
// scope package
// sample type, widths, register map and the
// configuration and control structs
//////////////////////////////

package scope_pkg;

  // ADC sample
  typedef logic signed [16-1:0] sample_t;

  // widths
  localparam int unsigned CNT_W  = 32;
  localparam int unsigned DEC_W  = 17;
  localparam int unsigned SHR_W  = 4;
  localparam int unsigned EVT_W  = 4;
  localparam int unsigned ADDR_W = 7;

  //////////////////////////////
  // register offsets
  //////////////////////////////

  localparam logic [ADDR_W-1:0] REG_CTL     = 7'h00;
  localparam logic [ADDR_W-1:0] REG_MODE    = 7'h04;
  localparam logic [ADDR_W-1:0] REG_MASK    = 7'h08;
  localparam logic [ADDR_W-1:0] REG_PRE     = 7'h10;
  localparam logic [ADDR_W-1:0] REG_PST     = 7'h14;
  localparam logic [ADDR_W-1:0] REG_STS_PRE = 7'h18;
  localparam logic [ADDR_W-1:0] REG_STS_PST = 7'h1c;
  localparam logic [ADDR_W-1:0] REG_POS     = 7'h40;
  localparam logic [ADDR_W-1:0] REG_NEG     = 7'h44;
  localparam logic [ADDR_W-1:0] REG_EDGE    = 7'h48;
  localparam logic [ADDR_W-1:0] REG_DEC     = 7'h50;
  localparam logic [ADDR_W-1:0] REG_SHR     = 7'h54;
  localparam logic [ADDR_W-1:0] REG_AVG     = 7'h58;

  // static configuration, held in the register bank
  typedef struct packed {
    logic             con;  // continuous
    logic [EVT_W-1:0] msk;  // external trigger mask
    logic [CNT_W-1:0] pre;  // pre-trigger samples
    logic [CNT_W-1:0] pst;  // post-trigger samples
    sample_t          pos;  // positive level
    sample_t          neg;  // negative level
    logic             edg;  // 0 rising, 1 falling
    logic [DEC_W-1:0] dec;  // decimation factor
    logic [SHR_W-1:0] shr;  // averaging shift
    logic             avg;  // averaging enable
  } scope_cfg_t;

  // single cycle control pulses
  typedef struct packed {
    logic rst;  // pipeline reset
    logic str;  // start
    logic stp;  // stop
    logic trg;  // software trigger
  } scope_ctl_t;

endpackage

/* design/scope_regs.sv */
//////////////////////////////
// scope register bank
// decodes bus writes into the configuration,
// turns control writes into pulses and
// reads back configuration and status
//////////////////////////////

`timescale 1ns/1ps

module scope_regs import scope_pkg::*; (
  input  logic              bus,
  input  logic              reset,
  // bus access
  input  logic              wen,
  input  logic              ren,
  input  logic [ADDR_W-1:0] addr,
  input  logic [32-1:0]     wdata,
  output logic [32-1:0]     rdata,
  output logic              ack,
  // configuration and control
  output scope_cfg_t        cfg,
  output scope_ctl_t        ctl,
  // status from the sequencer
  input  logic [CNT_W-1:0]  sts_pre,
  input  logic [CNT_W-1:0]  sts_pst,
  input  logic              sts_armed,
  input  logic              sts_stopped,
  input  logic              sts_triggered
);

  // every access is answered one cycle later
  always_ff @(posedge bus) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= wen | ren;
    end
  end

  //////////////////////////////
  // write decode
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      cfg     <= '0;
      // pass every sample by default
      cfg.dec <= DEC_W'(1);
    end else if (wen) begin
      case (addr)
        REG_MODE: cfg.con <= wdata[0];
        REG_MASK: cfg.msk <= wdata[EVT_W-1:0];
        REG_PRE:  cfg.pre <= wdata[CNT_W-1:0];
        REG_PST:  cfg.pst <= wdata[CNT_W-1:0];
        REG_POS:  cfg.pos <= wdata[$bits(sample_t)-1:0];
        REG_NEG:  cfg.neg <= wdata[$bits(sample_t)-1:0];
        REG_EDGE: cfg.edg <= wdata[0];
        REG_DEC:  cfg.dec <= wdata[DEC_W-1:0];
        REG_SHR:  cfg.shr <= wdata[SHR_W-1:0];
        REG_AVG:  cfg.avg <= wdata[0];
        default: ;
      endcase
    end
  end

  // control register, each bit a one cycle pulse
  always_ff @(posedge bus) begin
    if (reset) begin
      ctl <= '0;
    end else begin
      ctl <= '0;
      if (wen && (addr == REG_CTL)) begin
        ctl.rst <= wdata[0];
        ctl.str <= wdata[1];
        ctl.stp <= wdata[2];
        ctl.trg <= wdata[3];
      end
    end
  end

  //////////////////////////////
  // read mux
  //////////////////////////////

  // rdata lines up with ack
  always_ff @(posedge bus) begin
    if (ren) begin
      case (addr)
        // control offset returns sequencer status
        REG_CTL:     rdata <= {28'd0, sts_triggered, sts_stopped, sts_armed, 1'b0};
        REG_MODE:    rdata <= 32'(cfg.con);
        REG_MASK:    rdata <= 32'(cfg.msk);
        REG_PRE:     rdata <= 32'(cfg.pre);
        REG_PST:     rdata <= 32'(cfg.pst);
        REG_STS_PRE: rdata <= 32'(sts_pre);
        REG_STS_PST: rdata <= 32'(sts_pst);
        // levels come back sign extended
        REG_POS:     rdata <= 32'(cfg.pos);
        REG_NEG:     rdata <= 32'(cfg.neg);
        REG_EDGE:    rdata <= 32'(cfg.edg);
        REG_DEC:     rdata <= 32'(cfg.dec);
        REG_SHR:     rdata <= 32'(cfg.shr);
        REG_AVG:     rdata <= 32'(cfg.avg);
        default:     rdata <= '0;
      endcase
    end
  end

endmodule

/* design/scope_top.sv */
//////////////////////////////
// scope acquisition core
// registers, decimator, level trigger
// and acquisition sequencer
//////////////////////////////

`timescale 1ns/1ps

module scope_top import scope_pkg::*; #(
  parameter type sample_type = sample_t
) (
  input  logic              bus,
  input  logic              reset,
  // register access
  input  logic              wen,
  input  logic              ren,
  input  logic [ADDR_W-1:0] addr,
  input  logic [32-1:0]     wdata,
  output logic [32-1:0]     rdata,
  output logic              ack,
  // input stream
  input  sample_type        in_data,
  input  logic              in_valid,
  output logic              in_ready,
  // output stream
  output sample_type        out_data,
  output logic              out_valid,
  input  logic              out_ready,
  output logic              out_last,
  // events
  input  logic [EVT_W-1:0]  ext_event,
  output logic              edge_event
);

  scope_cfg_t       cfg;
  scope_ctl_t       ctl;
  logic [CNT_W-1:0] sts_pre;
  logic [CNT_W-1:0] sts_pst;
  logic             sts_armed;
  logic             sts_stopped;
  logic             sts_triggered;

  // streams between the stages
  sample_stream_if #(.sample_type(sample_type)) in_st ();
  sample_stream_if #(.sample_type(sample_type)) dec_to_edge ();
  sample_stream_if #(.sample_type(sample_type)) edge_to_acq ();
  sample_stream_if #(.sample_type(sample_type)) out_st ();

  // input port to stream, no last on the input side
  assign in_st.data  = in_data;
  assign in_st.valid = in_valid;
  assign in_st.last  = 1'b0;
  assign in_ready    = in_st.ready;

  // output stream to ports
  assign out_data     = out_st.data;
  assign out_valid    = out_st.valid;
  assign out_last     = out_st.last;
  assign out_st.ready = out_ready;

  scope_regs regs_i (
    .bus, .reset,
    .wen, .ren, .addr, .wdata, .rdata, .ack,
    .cfg, .ctl,
    .sts_pre, .sts_pst, .sts_armed, .sts_stopped, .sts_triggered
  );

  scope_dec_avg #(.sample_type(sample_type)) dec_avg_i (
    .bus, .reset, .cfg, .ctl,
    .sti (in_st),
    .sto (dec_to_edge)
  );

  scope_edge #(.sample_type(sample_type)) edge_i (
    .bus, .reset, .cfg, .ctl,
    .sti      (dec_to_edge),
    .sto      (edge_to_acq),
    .edge_trg (edge_event)
  );

  scope_acq #(.sample_type(sample_type)) acq_i (
    .bus, .reset, .cfg, .ctl,
    .ext_event,
    .edge_trg (edge_event),
    .sti      (edge_to_acq),
    .sto      (out_st),
    .sts_pre, .sts_pst, .sts_armed, .sts_stopped, .sts_triggered
  );

endmodule

/* verification/scope_tb.sv */
//////////////////////////////
// scope core testbench
// register, decimation, trigger and
// acquisition checks against a model
//////////////////////////////

`timescale 1ns/1ps

module scope_tb import scope_pkg::*; ();

  localparam int TMO = 2000;

  logic bus = 1'b0;
  logic reset, wen, ren, in_valid, in_ready, out_ready, out_valid, out_last, ack, edge_event;
  logic [ADDR_W-1:0] addr;
  logic [31:0] wdata, rdata, rd;
  logic [EVT_W-1:0] ext_event;
  sample_t in_data, out_data, ramp;

  int errors = 0;
  int timeouts = 0;
  int beats = 0;
  int edges = 0;
  int run_beats = 0;
  int runs_done = 0;
  int pre_n = 5;
  int pst_n = 7;
  int dec_factors[3] = '{1, 3, 8};
  int b0;
  bit model_on = 0;
  bit feed_on = 0;
  bit rand_stall = 0;
  bit edge_pend = 0;

  // reference model state
  int m_dec, m_shr, m_cnt, m_fires;
  bit m_avg, m_edg, m_armed;
  longint m_acc;
  sample_t m_pos, m_neg;
  sample_t exp_data[$];
  bit exp_edge[$];

  scope_top scope_top_i (
    .bus, .reset, .wen, .ren, .addr, .wdata, .rdata, .ack,
    .in_data, .in_valid, .in_ready, .out_data, .out_valid, .out_ready, .out_last,
    .ext_event, .edge_event
  );

  initial forever #2 bus = ~bus;

  //////////////////////////////
  // concurrent checks
  //////////////////////////////

  ack_follows_access: assert property (@(posedge bus) disable iff (reset)
    (wen || ren) |=> ack)
    else begin
      errors++;
      $display("Fail %0t: no ack after access", $time);
    end
  no_spurious_ack: assert property (@(posedge bus) disable iff (reset)
    !(wen || ren) |=> !ack)
    else begin
      errors++;
      $display("Fail %0t: ack without access", $time);
    end
  quiet_after_reset: assert property (@(posedge bus)
    $fell(reset) |-> (!ack && !out_valid && !out_last && !edge_event))
    else begin
      errors++;
      $display("Fail %0t: outputs active after reset", $time);
    end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
    assert (got === exp)
      else begin
        errors++;
        $display("Fail %0t: %s got %h expected %h", $time, msg, got, exp);
      end
  endtask

  // edge model on decimator output
  task automatic edge_model(input sample_t v);
    bit fire;
    bit arm;
    fire = m_armed && (m_edg ? (v <= m_neg) : (v >= m_pos));
    arm  = m_edg ? (v > m_pos) : (v < m_neg);
    if (fire) m_armed = 0;
    else if (arm) m_armed = 1;
    if (fire) m_fires++;
    exp_data.push_back(v);
    exp_edge.push_back(fire);
  endtask

  // decimation and averaging model
  // a factor of 0 or 1 passes every sample
  task automatic model_feed(input sample_t s);
    int f;
    f = (m_dec <= 1) ? 1 : m_dec;
    m_acc += s;
    m_cnt++;
    if (m_cnt == f) begin
      edge_model(m_avg ? sample_t'(m_acc >>> m_shr) : s);
      m_cnt = 0;
      m_acc = 0;
    end
  endtask

  //////////////////////////////
  // bus and stream tasks
  //////////////////////////////

  task automatic await_ack();
    int t;
    t = 0;
    @(negedge bus);
    while (!ack && t < TMO) begin
      @(negedge bus);
      t++;
    end
    if (!ack) begin
      timeouts++;
      $display("timeout: bus access never acknowledged");
    end
    rd = rdata;
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [31:0] d);
    @(posedge bus);
    wen <= 1'b1;
    addr <= a;
    wdata <= d;
    @(posedge bus);
    wen <= 1'b0;
    await_ack();
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] a);
    @(posedge bus);
    ren <= 1'b1;
    addr <= a;
    @(posedge bus);
    ren <= 1'b0;
    await_ack();
  endtask

  task automatic send_sample(input sample_t s);
    int t;
    @(posedge bus);
    in_data <= s;
    in_valid <= 1'b1;
    t = 0;
    @(negedge bus);
    while (!in_ready && t < TMO) begin
      @(negedge bus);
      t++;
    end
    if (!in_ready) begin
      timeouts++;
      $display("timeout: sample never accepted");
    end else if (model_on) begin
      model_feed(s);
    end
    @(posedge bus);
    in_valid <= 1'b0;
  endtask

  task automatic wait_until_drained();
    int t;
    t = 0;
    while (exp_data.size() != 0 && t < TMO) begin
      @(negedge bus);
      t++;
    end
    if (exp_data.size() != 0) begin
      timeouts++;
      $display("timeout: expected samples missing");
    end
  endtask

  task automatic wait_pre_done();
    int t;
    t = 0;
    bus_read(REG_STS_PRE);
    while (rd != pre_n && t < TMO) begin
      bus_read(REG_STS_PRE);
      t++;
    end
    if (rd != pre_n) begin
      timeouts++;
      $display("timeout: pre run never completed");
    end
  endtask

  task automatic wait_runs(input int n);
    int t;
    t = 0;
    while (runs_done < n && t < TMO) begin
      @(negedge bus);
      t++;
    end
    if (runs_done < n) begin
      timeouts++;
      $display("timeout: run never ended");
    end
  endtask

  // stop, configure, clear pipeline and start a long pre run
  task automatic stream_setup(input int dec, input bit avg, input int shr, input bit edg,
                              input sample_t pos, input sample_t neg);
    model_on = 0;
    bus_write(REG_CTL, 32'h4);
    repeat (10) @(posedge bus);
    bus_write(REG_DEC, dec);
    bus_write(REG_AVG, avg);
    bus_write(REG_SHR, shr);
    bus_write(REG_EDGE, edg);
    bus_write(REG_POS, 32'(pos));
    bus_write(REG_NEG, 32'(neg));
    bus_write(REG_PRE, 100000);
    bus_write(REG_CTL, 32'h1);
    {m_dec, m_avg, m_shr, m_edg, m_pos, m_neg} = {dec, avg, shr, edg, pos, neg};
    {m_cnt, m_acc, m_armed, m_fires, edge_pend} = '0;
    bus_write(REG_CTL, 32'h2);
    model_on = 1;
  endtask

  // one acquisition run
  // kind 0 software, 1 external event, 2 level trigger
  task automatic acq_run(input int kind);
    int r0;
    r0 = runs_done;
    run_beats = 0;
    bus_write(REG_POS, kind == 2 ? 32'd100 : 32'h7fff);
    bus_write(REG_NEG, kind == 2 ? -32'sd100 : 32'hffff8000);
    bus_write(REG_CTL, 32'h2);
    wait_pre_done();
    if (kind == 0) bus_write(REG_CTL, 32'h8);
    if (kind == 1) begin
      // unmasked event first
      @(posedge bus) ext_event <= 4'b0100;
      @(posedge bus) ext_event <= 4'b0000;
      repeat (20) @(posedge bus);
      bus_read(REG_CTL);
      check_value(rd[3], 1'b0, "unmasked event triggered");
      @(posedge bus) ext_event <= 4'b0010;
      @(posedge bus) ext_event <= 4'b0000;
    end
    wait_runs(r0 + 1);
    bus_read(REG_STS_PST);
    check_value(rd, pst_n, "post count status");
  endtask

  //////////////////////////////
  // output monitor
  //////////////////////////////

  always @(negedge bus) begin
    if (!reset) begin
      if (edge_event) begin
        edge_pend = 1;
        edges++;
      end
      if (out_valid && out_ready) begin
        beats++;
        if (model_on) begin
          if (exp_data.size() == 0) begin
            errors++;
            $display("Fail %0t: unexpected output sample %h", $time, out_data);
          end else begin
            check_value(32'(out_data), 32'(exp_data.pop_front()), "output sample");
            check_value(edge_pend, exp_edge.pop_front(), "edge_event");
          end
        end else if (out_last) begin
          check_value(run_beats, pre_n + pst_n - 1, "samples before last");
          run_beats = 0;
          runs_done++;
        end else begin
          run_beats++;
          assert (run_beats < pre_n + pst_n)
            else begin
              errors++;
              $display("Fail %0t: run without last", $time);
            end
        end
        edge_pend = 0;
      end
    end
  end

  // background ramp source for acquisition runs
  initial begin
    ramp = -200;
    forever begin
      if (feed_on) begin
        send_sample(ramp);
        ramp = (ramp >= 200) ? -200 : ramp + 20;
      end else begin
        @(posedge bus);
      end
    end
  end

  initial begin
    #2000000;
    $display("simulation limit reached before the end of the run");
    $display("Something failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h99a9));
    reset <= 1'b1;
    {wen, ren, in_valid} <= '0;
    out_ready <= 1'b1;
    {addr, wdata, in_data, ext_event} <= '0;
    // output back pressure, random once stalls are on
    fork
      forever begin
        @(posedge bus);
        out_ready <= rand_stall ? ($urandom_range(3) != 0) : 1'b1;
      end
    join_none
    repeat (10) @(posedge bus);
    reset <= 1'b0;

    // register access
    bus_read(REG_CTL);
    check_value(rd, 0, "status after reset");
    bus_write(REG_PRE, 32'h1234);
    bus_read(REG_PRE);
    check_value(rd, 32'h1234, "pre readback");
    bus_write(REG_POS, 32'h8001);
    bus_read(REG_POS);
    check_value(rd, 32'hffff8001, "level readback");
    bus_write(REG_DEC, 32'h1ffff);
    bus_read(REG_DEC);
    check_value(rd, 32'h1ffff, "factor readback");
    bus_read(7'h0c);
    check_value(rd, 0, "unused offset");

    // decimation with stalls
    rand_stall = 1;
    foreach (dec_factors[i]) begin
      stream_setup(dec_factors[i], 0, 0, 0, 16'sh7fff, -16'sh8000);
      b0 = beats;
      repeat (24) send_sample(sample_t'($urandom));
      wait_until_drained();
      check_value(beats - b0, 24 / dec_factors[i], "output count");
    end

    // averaging, mixed signs
    stream_setup(4, 1, 2, 0, 16'sh7fff, -16'sh8000);
    repeat (24) send_sample(sample_t'(int'($urandom_range(6000)) - 3000));
    wait_until_drained();

    // level trigger both ways
    for (int e = 0; e < 2; e++) begin
      stream_setup(1, 0, 0, e, 100, -100);
      b0 = edges;
      repeat (3) begin
        for (int v = -200; v <= 200; v += 25) send_sample(sample_t'(v));
        for (int v = 200; v >= -200; v -= 25) send_sample(sample_t'(v));
      end
      wait_until_drained();
      check_value(edges - b0, m_fires, "edge_event count");
    end

    // acquisition runs
    stream_setup(1, 0, 0, 0, 16'sh7fff, -16'sh8000);
    model_on = 0;
    bus_write(REG_CTL, 32'h4);
    bus_write(REG_PRE, pre_n);
    bus_write(REG_PST, pst_n);
    bus_write(REG_MASK, 32'h2);
    feed_on = 1;
    for (int k = 0; k < 3; k++) begin
      acq_run(k);
      bus_read(REG_CTL);
      check_value(rd[3:1], 3'b100, "status after run");
    end

    // continuous mode then stop
    bus_write(REG_MODE, 1);
    run_beats = 0;
    bus_write(REG_CTL, 32'h2);
    for (int k = 0; k < 2; k++) begin
      wait_pre_done();
      b0 = runs_done;
      bus_write(REG_CTL, 32'h8);
      wait_runs(b0 + 1);
      bus_read(REG_CTL);
      check_value(rd[1], 1'b1, "re-armed after last");
    end
    bus_write(REG_CTL, 32'h4);
    repeat (5) @(posedge bus);
    b0 = beats;
    repeat (40) @(posedge bus);
    check_value(beats - b0, 0, "output after stop");
    bus_read(REG_CTL);
    check_value(rd[2:1], 2'b10, "stopped status");
    bus_write(REG_MODE, 0);
    feed_on = 0;

    $display("errors %0d timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
